// ==== rtl/tracker_macros.svh ====
// Sizing constants for the memory request tracker, included by packages and RTL that need them

`ifndef TRACKER_MACROS_SVH
`define TRACKER_MACROS_SVH

// Heap depth
// Also the number of requests that may be outstanding at memory
`define TRK_ENTRIES 16

// Memory address width
`define TRK_ADDR_BITS 32

// Read and write data width
`define TRK_DATA_BITS 32

// Width of the label the client attaches to each request
`define TRK_USER_BITS 8

// Heap lookup and free ports
// Port 0 serves read responses, port 1 serves write acknowledgments
`define TRK_RD_PORTS 2

// Port numbers as used by the response matcher
`define TRK_PORT_RD 0
`define TRK_PORT_WR 1

`endif

// ==== rtl/clientPkg.sv ====
// Client-side types for the memory request tracker: request opcode and user tag

`include "tracker_macros.svh"

package clientPkg;

    // Request opcode
    // One bit, since only reads and writes exist
    typedef enum logic
    {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } opcode_t;

    // Label chosen by the client
    // Handed back unchanged with the matching response
    typedef logic [`TRK_USER_BITS-1:0] userTag_t;

    // Response channels are told apart by opcode
    // Read data comes back on the read channel only
    localparam int OP_BITS = $bits(opcode_t);

    // Width of the per-request client context
    localparam int CTX_BITS = OP_BITS + `TRK_USER_BITS;

endpackage

// ==== rtl/memPkg.sv ====
// Memory-side types for the tracker: tag, address, data and the request record held in the heap

`include "tracker_macros.svh"

package memPkg;

    // Heap index
    // Sent to memory as the request tag and returned with the response
    typedef logic [$clog2(`TRK_ENTRIES)-1:0] memTag_t;

    // Memory address
    typedef logic [`TRK_ADDR_BITS-1:0] memAddr_t;

    // Read and write data
    typedef logic [`TRK_DATA_BITS-1:0] memData_t;

    // Request record kept while the request is at memory
    // Opcode, user tag and address, 41 bits in all
    // Write data is not kept, memory already has it
    typedef struct packed
    {
        clientPkg::opcode_t  op;
        clientPkg::userTag_t userTag;
        memAddr_t            addr;
    } reqMeta_t;

    // Record width
    localparam int META_BITS = $bits(reqMeta_t);

    // Tag width
    localparam int TAG_BITS = $bits(memTag_t);

endpackage

// ==== rtl/reqHeap.sv ====
// Round-robin heap holding in-flight request records, one allocate port and several lookup/free ports
`timescale 1ns/10ps

`include "tracker_macros.svh"

module reqHeap
#(
    parameter int N_ENTRIES    = `TRK_ENTRIES,
    parameter int N_READ_PORTS = `TRK_RD_PORTS
)
(
    input  logic                           clk,
    input  logic                           resetb,

    // Allocate port
    input  logic                           enq,
    input  memPkg::reqMeta_t               enqData,
    output logic                           notFull,
    output memPkg::memTag_t                allocIdx,

    // Lookup ports, data one cycle after request
    input  memPkg::memTag_t                readReq [0:N_READ_PORTS-1],
    output memPkg::reqMeta_t               readRsp [0:N_READ_PORTS-1],

    // Free ports
    input  logic                           free    [0:N_READ_PORTS-1],
    input  memPkg::memTag_t                freeIdx [0:N_READ_PORTS-1],

    // Busy entry count
    output logic [$clog2(N_ENTRIES):0]     inFlight
);

    localparam int CNT_W = $clog2(N_ENTRIES) + 1;

    // One bit per entry, set while the entry is free
    logic [N_ENTRIES-1:0] notBusy;

    // Round-robin allocation pointer
    memPkg::memTag_t nextAlloc;

    // Entries released this cycle over all free ports
    logic [CNT_W-1:0] freeCount;

    // Busy entry counter
    logic [CNT_W-1:0] inFlightQ;

    // Full means the entry at the pointer is still busy
    // Free entries elsewhere do not count
    assign notFull  = notBusy[nextAlloc];
    assign allocIdx = nextAlloc;
    assign inFlight = inFlightQ;

    // Pointer advances on every allocation and wraps at the last entry
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            nextAlloc <= '0;
        end
        else if (enq)
        begin
            nextAlloc <= (nextAlloc == memPkg::memTag_t'(N_ENTRIES - 1)) ?
                         '0 : nextAlloc + 1'b1;
        end
    end

    // Storage copied once per lookup port
    // All ports can read while an allocation writes
    for (genvar p = 0; p < N_READ_PORTS; p++)
    begin : g_port
        memPkg::reqMeta_t mem [0:N_ENTRIES-1];
        memPkg::reqMeta_t rspQ;

        always_ff @(posedge clk)
        begin
            rspQ <= mem[readReq[p]];
            if (enq)
            begin
                mem[allocIdx] <= enqData;
            end
        end

        assign readRsp[p] = rspQ;

        // Freed entry must currently be busy
        assert property (@(posedge clk) disable iff (!resetb)
            free[p] |-> !notBusy[freeIdx[p]])
            else $error("reqHeap: free of idle entry on port %0d", p);
    end

    // Count this cycle's frees
    always_comb
    begin
        freeCount = '0;
        for (int i = 0; i < N_READ_PORTS; i++)
        begin
            if (free[i])
            begin
                freeCount = freeCount + 1'b1;
            end
        end
    end

    // Free list and counter change on the same edge
    // A freed entry is free from the next cycle on
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            notBusy   <= '1;
            inFlightQ <= '0;
        end
        else
        begin
            if (enq)
            begin
                notBusy[allocIdx] <= 1'b0;
            end
            for (int i = 0; i < N_READ_PORTS; i++)
            begin
                if (free[i])
                begin
                    notBusy[freeIdx[i]] <= 1'b1;
                end
            end
            inFlightQ <= inFlightQ + CNT_W'(enq) - freeCount;
        end
    end

    // Allocation only into a free entry
    assert property (@(posedge clk) disable iff (!resetb) enq |-> notFull)
        else $error("reqHeap: enq while full");

endmodule

// ==== rtl/reqIssue.sv ====
// Request issue stage that stores accepted client requests in the heap and sends them to memory
`timescale 1ns/10ps

module reqIssue
(
    input  logic                clk,
    input  logic                resetb,

    // Client request
    input  logic                reqValid,
    input  clientPkg::opcode_t  reqOp,
    input  memPkg::memAddr_t    reqAddr,
    input  memPkg::memData_t    reqWrData,
    input  clientPkg::userTag_t reqUserTag,

    // Heap allocate port
    input  logic                notFull,
    input  memPkg::memTag_t     allocIdx,
    output logic                enq,
    output memPkg::reqMeta_t    enqData,

    // Memory request
    output logic                memReqValid,
    output clientPkg::opcode_t  memReqOp,
    output memPkg::memTag_t     memReqTag,
    output memPkg::memAddr_t    memReqAddr,
    output memPkg::memData_t    memReqWrData
);

    // Every client strobe is an accepted request
    assign enq = reqValid;

    // Record kept until the response returns
    always_comb
    begin
        enqData         = '0;
        enqData.op      = reqOp;
        enqData.userTag = reqUserTag;
        enqData.addr    = reqAddr;
    end

    // Memory strobe one cycle after acceptance
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            memReqValid <= 1'b0;
        end
        else
        begin
            memReqValid <= enq;
        end
    end

    // Request fields registered with the strobe
    // Tag is the entry the request was written to
    always_ff @(posedge clk)
    begin
        if (enq)
        begin
            memReqOp     <= reqOp;
            memReqTag    <= allocIdx;
            memReqAddr   <= reqAddr;
            memReqWrData <= reqWrData;
        end
    end

    // Client honours the fullness level from the heap
    assert property (@(posedge clk) disable iff (!resetb) reqValid |-> notFull)
        else $error("reqIssue: reqValid while heap full");

endmodule

// ==== rtl/rspMatch.sv ====
// Response matcher: looks up returning tags in the heap, frees them and builds client responses
`timescale 1ns/10ps

`include "tracker_macros.svh"

module rspMatch
(
    input  logic                clk,
    input  logic                resetb,

    // Memory read responses
    input  logic                rdRspValid,
    input  memPkg::memTag_t     rdRspTag,
    input  memPkg::memData_t    rdRspData,

    // Memory write acknowledgments
    input  logic                wrAckValid,
    input  memPkg::memTag_t     wrAckTag,

    // Heap lookup and free ports
    input  memPkg::reqMeta_t    readRsp [0:`TRK_RD_PORTS-1],
    output memPkg::memTag_t     readReq [0:`TRK_RD_PORTS-1],
    output logic                free    [0:`TRK_RD_PORTS-1],
    output memPkg::memTag_t     freeIdx [0:`TRK_RD_PORTS-1],

    // Client read responses
    output logic                cliRdValid,
    output clientPkg::userTag_t cliRdUserTag,
    output memPkg::memAddr_t    cliRdAddr,
    output memPkg::memData_t    cliRdData,

    // Client write acknowledgments
    output logic                cliWrValid,
    output clientPkg::userTag_t cliWrUserTag,
    output memPkg::memAddr_t    cliWrAddr
);

    // Strobes and read data delayed to meet the heap lookup
    logic             rdValidQ;
    logic             wrValidQ;
    memPkg::memData_t rdDataQ;

    // Lookup and free in the same cycle
    // Lookup result is captured before the entry can be reused
    assign readReq[`TRK_PORT_RD] = rdRspTag;
    assign free[`TRK_PORT_RD]    = rdRspValid;
    assign freeIdx[`TRK_PORT_RD] = rdRspTag;

    assign readReq[`TRK_PORT_WR] = wrAckTag;
    assign free[`TRK_PORT_WR]    = wrAckValid;
    assign freeIdx[`TRK_PORT_WR] = wrAckTag;

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            rdValidQ <= 1'b0;
            wrValidQ <= 1'b0;
        end
        else
        begin
            rdValidQ <= rdRspValid;
            wrValidQ <= wrAckValid;
        end
    end

    always_ff @(posedge clk)
    begin
        rdDataQ <= rdRspData;
    end

    // Client responses from the looked-up records
    assign cliRdValid   = rdValidQ;
    assign cliRdUserTag = readRsp[`TRK_PORT_RD].userTag;
    assign cliRdAddr    = readRsp[`TRK_PORT_RD].addr;
    assign cliRdData    = rdDataQ;

    assign cliWrValid   = wrValidQ;
    assign cliWrUserTag = readRsp[`TRK_PORT_WR].userTag;
    assign cliWrAddr    = readRsp[`TRK_PORT_WR].addr;

    // Stored opcode agrees with the channel that returned the tag
    assert property (@(posedge clk) disable iff (!resetb)
        rdValidQ |-> readRsp[`TRK_PORT_RD].op == clientPkg::OP_READ)
        else $error("rspMatch: read response for a write tag");
    assert property (@(posedge clk) disable iff (!resetb)
        wrValidQ |-> readRsp[`TRK_PORT_WR].op == clientPkg::OP_WRITE)
        else $error("rspMatch: write ack for a read tag");

endmodule

// ==== rtl/trackerTop.sv ====
// Memory request tracker top level: client and memory ports around issue, heap and match
`timescale 1ns/10ps

`include "tracker_macros.svh"

module trackerTop
(
    input  logic                          clk,
    input  logic                          resetb,

    // Client requests
    input  logic                          reqValid,
    input  clientPkg::opcode_t            reqOp,
    input  memPkg::memAddr_t              reqAddr,
    input  memPkg::memData_t              reqWrData,
    input  clientPkg::userTag_t           reqUserTag,
    output logic                          reqNotFull,

    // Memory requests
    output logic                          memReqValid,
    output clientPkg::opcode_t            memReqOp,
    output memPkg::memTag_t               memReqTag,
    output memPkg::memAddr_t              memReqAddr,
    output memPkg::memData_t              memReqWrData,

    // Memory responses
    input  logic                          rdRspValid,
    input  memPkg::memTag_t               rdRspTag,
    input  memPkg::memData_t              rdRspData,
    input  logic                          wrAckValid,
    input  memPkg::memTag_t               wrAckTag,

    // Client responses
    output logic                          cliRdValid,
    output clientPkg::userTag_t           cliRdUserTag,
    output memPkg::memAddr_t              cliRdAddr,
    output memPkg::memData_t              cliRdData,
    output logic                          cliWrValid,
    output clientPkg::userTag_t           cliWrUserTag,
    output memPkg::memAddr_t              cliWrAddr,

    // Busy entry count
    output logic [$clog2(`TRK_ENTRIES):0] inFlight
);

    // Heap allocate side
    logic             enq;
    memPkg::reqMeta_t enqData;
    memPkg::memTag_t  allocIdx;

    // Heap lookup and free side
    memPkg::memTag_t  readReq [0:`TRK_RD_PORTS-1];
    memPkg::reqMeta_t readRsp [0:`TRK_RD_PORTS-1];
    logic             free    [0:`TRK_RD_PORTS-1];
    memPkg::memTag_t  freeIdx [0:`TRK_RD_PORTS-1];

    reqIssue u_reqIssue (
        .clk, .resetb, .reqValid, .reqOp, .reqAddr, .reqWrData, .reqUserTag,
        .notFull (reqNotFull), .allocIdx, .enq, .enqData,
        .memReqValid, .memReqOp, .memReqTag, .memReqAddr, .memReqWrData
    );

    reqHeap #(.N_ENTRIES(`TRK_ENTRIES), .N_READ_PORTS(`TRK_RD_PORTS)) u_reqHeap (
        .clk, .resetb, .enq, .enqData, .notFull (reqNotFull), .allocIdx,
        .readReq, .readRsp, .free, .freeIdx, .inFlight
    );

    rspMatch u_rspMatch (
        .clk, .resetb, .rdRspValid, .rdRspTag, .rdRspData, .wrAckValid, .wrAckTag,
        .readRsp, .readReq, .free, .freeIdx,
        .cliRdValid, .cliRdUserTag, .cliRdAddr, .cliRdData,
        .cliWrValid, .cliWrUserTag, .cliWrAddr
    );

endmodule

// ==== sim/trackerTb.sv ====
// Testbench for the memory request tracker, random client traffic against an out-of-order memory
`timescale 1ns/10ps

`include "tracker_macros.svh"

module trackerTb;

    localparam int N_REQ = 400;
    // Allows 50 cycles for each of the 400 requests
    localparam int MAX_CYCLES = 20000;

    // Tag life cycle in the memory model
    localparam int TAG_FREE      = 0;
    localparam int TAG_ISSUED    = 1;
    localparam int TAG_READY     = 2;
    localparam int TAG_RETURNING = 3;

    logic clk;
    logic resetb;

    // DUT client and memory ports
    logic                          reqValid, reqNotFull, memReqValid;
    logic                          rdRspValid, wrAckValid, cliRdValid, cliWrValid;
    clientPkg::opcode_t            reqOp, memReqOp;
    memPkg::memAddr_t              reqAddr, memReqAddr, cliRdAddr, cliWrAddr;
    memPkg::memData_t              reqWrData, memReqWrData, rdRspData, cliRdData;
    clientPkg::userTag_t           reqUserTag, cliRdUserTag, cliWrUserTag;
    memPkg::memTag_t               memReqTag, rdRspTag, wrAckTag;
    logic [$clog2(`TRK_ENTRIES):0] inFlight;

    // Expected outputs for the current cycle
    logic                          expMemValid, expRdValid, expWrValid, expNotFull;
    clientPkg::opcode_t            expMemOp;
    memPkg::memTag_t               expMemTag;
    memPkg::memAddr_t              expMemAddr, expRdAddr, expWrAddr;
    memPkg::memData_t              expMemData, expRdData;
    clientPkg::userTag_t           expRdUser, expWrUser;
    logic [$clog2(`TRK_ENTRIES):0] expInFlight;

    // Reference table indexed by tag
    clientPkg::opcode_t            tblOp    [0:`TRK_ENTRIES-1];
    clientPkg::userTag_t           tblUser  [0:`TRK_ENTRIES-1];
    memPkg::memAddr_t              tblAddr  [0:`TRK_ENTRIES-1];
    int                            tagState [0:`TRK_ENTRIES-1];
    memPkg::memTag_t               ptr;
    logic [$clog2(`TRK_ENTRIES):0] busyCount;

    logic [31:0] lfsr;
    int          issued, accepted, bothCount, checkCount, errorCount, problemCount, cycleCount;
    bit          checksOn;

    trackerTop u_trackerTop (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            val  = {val[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return val;
    endfunction

    // Reference model, run at each rising edge on the inputs that edge consumes
    function automatic void predictEdge();
        expRdValid = rdRspValid;
        expWrValid = wrAckValid;
        if (rdRspValid && wrAckValid)
            bothCount++;
        // Returned tags are looked up and freed
        if (rdRspValid)
        begin
            expRdUser          = tblUser[rdRspTag];
            expRdAddr          = tblAddr[rdRspTag];
            expRdData          = rdRspData;
            tagState[rdRspTag] = TAG_FREE;
            busyCount          = busyCount - 1'b1;
        end
        if (wrAckValid)
        begin
            expWrUser          = tblUser[wrAckTag];
            expWrAddr          = tblAddr[wrAckTag];
            tagState[wrAckTag] = TAG_FREE;
            busyCount          = busyCount - 1'b1;
        end
        // Memory saw last cycle's requests
        for (int t = 0; t < `TRK_ENTRIES; t++)
            if (tagState[t] == TAG_ISSUED)
                tagState[t] = TAG_READY;
        // Accepted request takes the entry at the pointer
        expMemValid = reqValid;
        if (reqValid)
        begin
            tblOp[ptr]    = reqOp;
            tblUser[ptr]  = reqUserTag;
            tblAddr[ptr]  = reqAddr;
            expMemOp      = reqOp;
            expMemTag     = ptr;
            expMemAddr    = reqAddr;
            expMemData    = reqWrData;
            tagState[ptr] = TAG_ISSUED;
            busyCount     = busyCount + 1'b1;
            ptr           = ptr + 1'b1;
            accepted++;
        end
        expNotFull  = (tagState[ptr] == TAG_FREE);
        expInFlight = busyCount;
    endfunction

    // Next rising edge, model update, inputs back to idle
    task automatic advance();
        @(posedge clk);
        predictEdge();
        reqValid   <= 1'b0;
        rdRspValid <= 1'b0;
        wrAckValid <= 1'b0;
    endtask

    task automatic issueRequest();
        reqValid   <= 1'b1;
        reqOp      <= clientPkg::opcode_t'(takeBits(1));
        reqAddr    <= takeBits(32);
        reqWrData  <= takeBits(32);
        reqUserTag <= clientPkg::userTag_t'(takeBits(8));
        issued++;
    endtask

    // Channel follows the stored opcode
    task automatic sendReturn(input memPkg::memTag_t tag);
        tagState[tag] = TAG_RETURNING;
        if (tblOp[tag] == clientPkg::OP_READ)
        begin
            rdRspValid <= 1'b1;
            rdRspTag   <= tag;
            rdRspData  <= takeBits(32);
        end
        else
        begin
            wrAckValid <= 1'b1;
            wrAckTag   <= tag;
        end
    endtask

    // Search from a random tag for one that may come back
    task automatic returnOne(input clientPkg::opcode_t op);
        memPkg::memTag_t tag;
        tag = memPkg::memTag_t'(takeBits(4));
        for (int k = 0; k < `TRK_ENTRIES; k++)
        begin
            if (tagState[tag] == TAG_READY && tblOp[tag] == op)
            begin
                sendReturn(tag);
                break;
            end
            tag = tag + 1'b1;
        end
    endtask

    task automatic flagMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        errorCount++;
        $display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    endtask

    task automatic flagProblem(input string what);
        problemCount++;
        $display("Error: %s at %0t", what, $time);
    endtask

    // Mid-cycle compare against the model
    always @(negedge clk)
    begin
        if (checksOn)
        begin
            checkCount++;
            if (memReqValid !== expMemValid)
                flagMismatch("memReqValid", 32'(memReqValid), 32'(expMemValid));
            if (expMemValid)
            begin
                if (memReqOp !== expMemOp)
                    flagMismatch("memReqOp", 32'(memReqOp), 32'(expMemOp));
                if (memReqTag !== expMemTag)
                    flagMismatch("memReqTag", 32'(memReqTag), 32'(expMemTag));
                if (memReqAddr !== expMemAddr)
                    flagMismatch("memReqAddr", memReqAddr, expMemAddr);
                if (memReqWrData !== expMemData)
                    flagMismatch("memReqWrData", memReqWrData, expMemData);
            end
            if (cliRdValid !== expRdValid)
                flagMismatch("cliRdValid", 32'(cliRdValid), 32'(expRdValid));
            if (expRdValid)
            begin
                if (cliRdUserTag !== expRdUser)
                    flagMismatch("cliRdUserTag", 32'(cliRdUserTag), 32'(expRdUser));
                if (cliRdAddr !== expRdAddr)
                    flagMismatch("cliRdAddr", cliRdAddr, expRdAddr);
                if (cliRdData !== expRdData)
                    flagMismatch("cliRdData", cliRdData, expRdData);
            end
            if (cliWrValid !== expWrValid)
                flagMismatch("cliWrValid", 32'(cliWrValid), 32'(expWrValid));
            if (expWrValid)
            begin
                if (cliWrUserTag !== expWrUser)
                    flagMismatch("cliWrUserTag", 32'(cliWrUserTag), 32'(expWrUser));
                if (cliWrAddr !== expWrAddr)
                    flagMismatch("cliWrAddr", cliWrAddr, expWrAddr);
            end
            if (reqNotFull !== expNotFull)
                flagMismatch("reqNotFull", 32'(reqNotFull), 32'(expNotFull));
            if (inFlight !== expInFlight)
                flagMismatch("inFlight", 32'(inFlight), 32'(expInFlight));
        end
    end

    initial
    begin
        cycleCount = 0;
        while (cycleCount < MAX_CYCLES)
        begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: run still busy after %0d cycles with %0d of %0d requests accepted",
                 MAX_CYCLES, accepted, N_REQ);
        $display("Verification failed");
        $finish;
    end

    initial
    begin
        resetb     = 1'b0;
        reqValid   = 1'b0;
        reqOp      = clientPkg::OP_READ;
        reqAddr    = '0;
        reqWrData  = '0;
        reqUserTag = '0;
        rdRspValid = 1'b0;
        rdRspTag   = '0;
        rdRspData  = '0;
        wrAckValid = 1'b0;
        wrAckTag   = '0;
        lfsr       = 32'h309b_af02;
        // Model starts in the reset state
        for (int t = 0; t < `TRK_ENTRIES; t++)
            tagState[t] = TAG_FREE;
        ptr         = '0;
        busyCount   = '0;
        expMemValid = 1'b0;
        expRdValid  = 1'b0;
        expWrValid  = 1'b0;
        expNotFull  = 1'b1;
        expInFlight = '0;

        // Reset held for 4 edges, outputs checked from the first one
        @(posedge clk);
        checksOn = 1'b1;
        repeat (3) @(posedge clk);
        resetb <= 1'b1;

        // Fill every entry with no returns
        // Pointer wraps to entry 0, still busy
        repeat (`TRK_ENTRIES)
        begin
            advance();
            issueRequest();
        end
        advance();
        sendReturn(memPkg::memTag_t'(5));
        advance();
        sendReturn(memPkg::memTag_t'(0));
        @(negedge clk);
        if (reqNotFull !== 1'b0)
            flagProblem("reqNotFull rose after freeing an entry away from the pointer");
        advance();
        @(negedge clk);
        if (reqNotFull !== 1'b1)
            flagProblem("reqNotFull stayed low after the entry at the pointer was freed");

        // Random traffic with out-of-order returns on both channels
        while (accepted < N_REQ || busyCount != 0)
        begin
            advance();
            if (issued < N_REQ && tagState[ptr] == TAG_FREE && takeBits(2) != 0)
                issueRequest();
            if (takeBits(1) != 0)
                returnOne(clientPkg::OP_READ);
            if (takeBits(1) != 0)
                returnOne(clientPkg::OP_WRITE);
        end

        // Last client responses still to be compared
        repeat (3) advance();
        @(posedge clk);
        if (bothCount == 0)
            flagProblem("no cycle carried a read response and a write ack together");
        $display("%0d requests, %0d cycles checked, %0d value errors, %0d other errors",
                 accepted, checkCount, errorCount, problemCount);
        if (errorCount == 0 && problemCount == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== memTracker.f ====
+incdir+rtl
rtl/clientPkg.sv
rtl/memPkg.sv
rtl/reqHeap.sv
rtl/reqIssue.sv
rtl/rspMatch.sv
rtl/trackerTop.sv
sim/trackerTb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the tracker testbench with Verilator, run it, look for the pass line in the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module trackerTb -o trackerSim \
    -f memTracker.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Build failed"
    exit 1
fi

./obj_dir/trackerSim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Pass only when the testbench printed its pass line
if grep -qx "Verification passed" "$SIM_LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
